/* logic/fetch_addr.sv */
module fetch_addr (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start_of_screen,
    input  logic                              start_of_line,
    layer_cfg_if.user                         cfg,
    input  logic [7:0]                        col,
    input  logic [render_pkg::BUS_DATA_W-1:0] map_word,
    output logic [render_pkg::BUS_ADDR_W-1:0] map_addr,
    output logic [render_pkg::BUS_ADDR_W-1:0] tile_addr,
    output render_pkg::map_entry_t            entry,
    output logic                              half_odd
);

    logic [11:0] line_r;
    logic [11:0] next_line_r;
    logic [11:0] line_base;
    logic [11:0] scrolled;
    logic [7:0]  map_row;
    logic [7:0]  map_col;
    logic [15:0] idx;

    // Line counter, a new screen starts again at line 0
    assign line_base = start_of_screen ? 12'd0 : next_line_r;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_r      <= 12'd0;
            next_line_r <= 12'd0;
        end else if (start_of_line) begin
            line_r      <= line_base;
            next_line_r <= line_base + 12'd1;
        end else if (start_of_screen) begin
            next_line_r <= 12'd0;
        end
    end

    always_comb begin
        scrolled = line_r + cfg.vscroll;
        map_col  = col + cfg.hscroll[10:3];

        // Wrap row to the map height
        case (cfg.map_height)
            2'd0:    map_row = {3'b0, scrolled[7:3]};
            2'd1:    map_row = {2'b0, scrolled[8:3]};
            2'd2:    map_row = {1'b0, scrolled[9:3]};
            default: map_row = scrolled[10:3];
        endcase

        // Row times width plus wrapped column
        case (cfg.map_width)
            2'd0:    idx = {3'b0, map_row, map_col[4:0]};
            2'd1:    idx = {2'b0, map_row, map_col[5:0]};
            2'd2:    idx = {1'b0, map_row, map_col[6:0]};
            default: idx = {map_row, map_col};
        endcase

        half_odd = idx[0];
        map_addr = {cfg.map_base + {1'b0, idx[15:1]}, 2'b00};
        entry    = half_odd ? map_word[31:16] : map_word[15:0];

        // 1bpp keeps the row byte in the low address bits
        if (cfg.mode == render_pkg::RENDER_4BPP) begin
            tile_addr = {cfg.tile_base, 2'b00} + {3'b0, entry.attr4.tile, scrolled[2:0], 2'b00};
        end else begin
            tile_addr = {cfg.tile_base, 2'b00} + {7'b0, entry.attr1.tile, scrolled[2:0]};
        end
    end

endmodule

/* logic/fetch_ctrl.sv */
module fetch_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start_of_line,
    input  logic [render_pkg::BUS_DATA_W-1:0] bus_rddata,
    input  logic                              bus_ack,
    input  logic [render_pkg::BUS_ADDR_W-1:0] map_addr,
    input  logic [render_pkg::BUS_ADDR_W-1:0] tile_addr,
    input  logic                              half_odd,
    input  render_pkg::map_entry_t            entry,
    layer_cfg_if.user                         cfg,
    pixel_job_if.ctrl                         job,
    output logic [render_pkg::BUS_ADDR_W-1:0] bus_addr,
    output logic                              bus_strobe,
    output logic [7:0]                        col,
    output logic [render_pkg::BUS_DATA_W-1:0] map_word
);

    logic [2:0]  state;
    logic        strobe_r;
    logic        issue;
    logic [1:0]  byte_sel;
    logic [31:0] tile_word;
    logic [7:0]  row_byte;

    // Strobe falls in the ack cycle
    assign bus_strobe = strobe_r && !bus_ack;
    assign issue      = (state == render_pkg::ST_ISSUE) && !job.busy && !job.line_done;
    assign row_byte   = tile_word[{byte_sel, 3'b000} +: 8];

    ////////////////////////////////////////
    // Fetch FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= render_pkg::ST_IDLE;
            strobe_r  <= 1'b0;
            col       <= 8'd0;
            job.start <= 1'b0;
        end else begin
            job.start <= 1'b0;
            case (state)
                render_pkg::ST_FETCH_MAP: begin
                    strobe_r <= 1'b1;
                    state    <= render_pkg::ST_WAIT_MAP;
                end
                render_pkg::ST_WAIT_MAP: begin
                    if (bus_ack) begin
                        strobe_r <= 1'b0;
                        state    <= render_pkg::ST_FETCH_TILE;
                    end
                end
                render_pkg::ST_FETCH_TILE: begin
                    strobe_r <= 1'b1;
                    state    <= render_pkg::ST_WAIT_TILE;
                end
                render_pkg::ST_WAIT_TILE: begin
                    if (bus_ack) begin
                        strobe_r <= 1'b0;
                        state    <= render_pkg::ST_ISSUE;
                    end
                end
                render_pkg::ST_ISSUE: begin
                    // Odd half used up, next column needs a new map word
                    if (issue) begin
                        job.start <= 1'b1;
                        col       <= col + 8'd1;
                        state     <= half_odd ? render_pkg::ST_FETCH_MAP
                                              : render_pkg::ST_FETCH_TILE;
                    end
                end
                default: ;
            endcase

            // Stop only between bus cycles
            if (job.line_done && !strobe_r) begin
                state    <= render_pkg::ST_IDLE;
                strobe_r <= 1'b0;
            end

            if (start_of_line) begin
                state    <= render_pkg::ST_FETCH_MAP;
                strobe_r <= 1'b0;
                col      <= 8'd0;
            end
        end
    end

    // Address, fetched words and job payload
    always_ff @(posedge clk) begin
        if (state == render_pkg::ST_FETCH_MAP) begin
            bus_addr <= map_addr;
        end
        if (state == render_pkg::ST_FETCH_TILE) begin
            bus_addr <= {tile_addr[render_pkg::BUS_ADDR_W-1:2], 2'b00};
            byte_sel <= tile_addr[1:0];
        end
        if (state == render_pkg::ST_WAIT_MAP && bus_ack) begin
            map_word <= bus_rddata;
        end
        if (state == render_pkg::ST_WAIT_TILE && bus_ack) begin
            tile_word <= bus_rddata;
        end
        if (issue) begin
            job.row_data <= (cfg.mode == render_pkg::RENDER_4BPP) ? tile_word
                                                                  : {24'b0, row_byte};
            job.entry    <= entry;
        end
    end

endmodule

/* logic/layer_cfg_if.sv */
interface layer_cfg_if;

    render_pkg::render_mode_t mode;
    logic [1:0]               map_width;
    logic [1:0]               map_height;
    logic [15:0]              map_base;
    logic [15:0]              tile_base;
    logic [11:0]              hscroll;
    logic [11:0]              vscroll;

    // Register file side
    modport regs (
        output mode, map_width, map_height, map_base, tile_base, hscroll, vscroll
    );

    // Datapath side
    modport user (
        input mode, map_width, map_height, map_base, tile_base, hscroll, vscroll
    );

endinterface

/* logic/layer_regs.sv */
module layer_regs (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [render_pkg::REG_ADDR_W-1:0] regs_addr,
    input  logic [render_pkg::REG_DATA_W-1:0] regs_wrdata,
    input  logic                              regs_write,
    output logic [render_pkg::REG_DATA_W-1:0] regs_rddata,
    layer_cfg_if.regs                         cfg
);

    ////////////////////////////////////////
    // Readback
    ////////////////////////////////////////
    always_comb begin
        case (regs_addr)
            render_pkg::REG_CTRL0:       regs_rddata = {7'b0, cfg.mode};
            render_pkg::REG_CTRL1:       regs_rddata = {4'b0, cfg.map_height, cfg.map_width};
            render_pkg::REG_MAP_BASE_L:  regs_rddata = cfg.map_base[7:0];
            render_pkg::REG_MAP_BASE_H:  regs_rddata = cfg.map_base[15:8];
            render_pkg::REG_TILE_BASE_L: regs_rddata = cfg.tile_base[7:0];
            render_pkg::REG_TILE_BASE_H: regs_rddata = cfg.tile_base[15:8];
            render_pkg::REG_HSCROLL_L:   regs_rddata = cfg.hscroll[7:0];
            render_pkg::REG_HSCROLL_H:   regs_rddata = {4'b0, cfg.hscroll[11:8]};
            render_pkg::REG_VSCROLL_L:   regs_rddata = cfg.vscroll[7:0];
            render_pkg::REG_VSCROLL_H:   regs_rddata = {4'b0, cfg.vscroll[11:8]};
            default:                     regs_rddata = 8'h00;
        endcase
    end

    ////////////////////////////////////////
    // Byte writes
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg.mode       <= render_pkg::RENDER_1BPP;
            cfg.map_width  <= 2'd0;
            cfg.map_height <= 2'd0;
            cfg.map_base   <= 16'h0000;
            cfg.tile_base  <= render_pkg::TILE_BASE_RESET;
            cfg.hscroll    <= 12'd0;
            cfg.vscroll    <= 12'd0;
        end else if (regs_write) begin
            case (regs_addr)
                render_pkg::REG_CTRL0: begin
                    cfg.mode <= render_pkg::render_mode_t'(regs_wrdata[0]);
                end
                render_pkg::REG_CTRL1: begin
                    cfg.map_height <= regs_wrdata[3:2];
                    cfg.map_width  <= regs_wrdata[1:0];
                end
                render_pkg::REG_MAP_BASE_L:  cfg.map_base[7:0]   <= regs_wrdata;
                render_pkg::REG_MAP_BASE_H:  cfg.map_base[15:8]  <= regs_wrdata;
                render_pkg::REG_TILE_BASE_L: cfg.tile_base[7:0]  <= regs_wrdata;
                render_pkg::REG_TILE_BASE_H: cfg.tile_base[15:8] <= regs_wrdata;
                render_pkg::REG_HSCROLL_L:   cfg.hscroll[7:0]    <= regs_wrdata;
                render_pkg::REG_HSCROLL_H:   cfg.hscroll[11:8]   <= regs_wrdata[3:0];
                render_pkg::REG_VSCROLL_L:   cfg.vscroll[7:0]    <= regs_wrdata;
                render_pkg::REG_VSCROLL_H:   cfg.vscroll[11:8]   <= regs_wrdata[3:0];
                default: ;
            endcase
        end
    end

endmodule

/* logic/layer_renderer.sv */
module layer_renderer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start_of_screen,
    input  logic                              start_of_line,
    input  logic [render_pkg::REG_ADDR_W-1:0] regs_addr,
    input  logic [render_pkg::REG_DATA_W-1:0] regs_wrdata,
    input  logic                              regs_write,
    output logic [render_pkg::REG_DATA_W-1:0] regs_rddata,
    output logic [render_pkg::BUS_ADDR_W-1:0] bus_addr,
    input  logic [render_pkg::BUS_DATA_W-1:0] bus_rddata,
    output logic                              bus_strobe,
    input  logic                              bus_ack,
    output logic [render_pkg::LB_IDX_W-1:0]   linebuf_wridx,
    output logic [7:0]                        linebuf_wrdata,
    output logic                              linebuf_wren
);

    logic [7:0]                        col;
    logic [render_pkg::BUS_DATA_W-1:0] map_word;
    logic [render_pkg::BUS_ADDR_W-1:0] map_addr;
    logic [render_pkg::BUS_ADDR_W-1:0] tile_addr;
    render_pkg::map_entry_t            entry;
    logic                              half_odd;

    layer_cfg_if cfg ();
    pixel_job_if job ();

    layer_regs regs0 (
        .clk(clk), .rst(rst), .regs_addr(regs_addr), .regs_wrdata(regs_wrdata),
        .regs_write(regs_write), .regs_rddata(regs_rddata), .cfg(cfg)
    );

    fetch_addr addr0 (
        .clk(clk), .rst(rst), .start_of_screen(start_of_screen),
        .start_of_line(start_of_line), .cfg(cfg), .col(col), .map_word(map_word),
        .map_addr(map_addr), .tile_addr(tile_addr), .entry(entry), .half_odd(half_odd)
    );

    fetch_ctrl ctrl0 (
        .clk(clk), .rst(rst), .start_of_line(start_of_line), .bus_rddata(bus_rddata),
        .bus_ack(bus_ack), .map_addr(map_addr), .tile_addr(tile_addr),
        .half_odd(half_odd), .entry(entry), .cfg(cfg), .job(job), .bus_addr(bus_addr),
        .bus_strobe(bus_strobe), .col(col), .map_word(map_word)
    );

    pixel_writer pix0 (
        .clk(clk), .rst(rst), .start_of_line(start_of_line), .cfg(cfg), .job(job),
        .linebuf_wridx(linebuf_wridx), .linebuf_wrdata(linebuf_wrdata),
        .linebuf_wren(linebuf_wren)
    );

endmodule

/* logic/pixel_job_if.sv */
interface pixel_job_if;

    logic                   start;
    logic [31:0]            row_data;
    render_pkg::map_entry_t entry;
    logic                   busy;
    logic                   line_done;

    // Fetch control hands out one tile row at a time
    modport ctrl (
        output start, row_data, entry,
        input  busy, line_done
    );

    modport pix (
        input  start, row_data, entry,
        output busy, line_done
    );

endinterface

/* logic/pixel_writer.sv */
module pixel_writer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start_of_line,
    layer_cfg_if.user                       cfg,
    pixel_job_if.pix                        job,
    output logic [render_pkg::LB_IDX_W-1:0] linebuf_wridx,
    output logic [7:0]                      linebuf_wrdata,
    output logic                            linebuf_wren
);

    logic                            active;
    logic [2:0]                      cnt;
    logic [render_pkg::LB_IDX_W-1:0] lb_idx;
    logic [31:0]                     row_r;
    render_pkg::map_entry_t          entry_r;
    logic [3:0]                      nib;
    logic                            bit_1bpp;
    logic [7:0]                      pix;
    logic                            write;

    assign job.line_done = (lb_idx == render_pkg::LB_IDX_W'(render_pkg::LINE_PIXELS));

    // Free during the last pixel so jobs can run back to back
    assign job.busy = active && (cnt != 3'd7);
    assign write    = active && !job.line_done;

    ////////////////////////////////////////
    // Pixel decode
    ////////////////////////////////////////
    always_comb begin
        // High nibble of each byte first
        nib      = row_r[{cnt[2:1], ~cnt[0], 2'b00} +: 4];
        bit_1bpp = row_r[~cnt];
        if (cfg.mode == render_pkg::RENDER_4BPP) begin
            pix = (nib != 4'h0) ? {entry_r.attr4.palette, nib} : 8'h00;
        end else begin
            pix = bit_1bpp ? {4'h0, entry_r.attr1.fg} : {4'h0, entry_r.attr1.bg};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active       <= 1'b0;
            cnt          <= 3'd0;
            lb_idx       <= '0;
            linebuf_wren <= 1'b0;
        end else begin
            linebuf_wren <= write;
            if (write) begin
                lb_idx <= lb_idx + 1'b1;
                cnt    <= cnt + 3'd1;
                if (cnt == 3'd7) begin
                    active <= 1'b0;
                end
            end else if (job.line_done) begin
                active <= 1'b0;
            end
            if (job.start) begin
                active <= 1'b1;
                cnt    <= 3'd0;
            end
            if (start_of_line) begin
                active <= 1'b0;
                lb_idx <= '0;
            end
        end
    end

    // Job capture and line buffer payload
    always_ff @(posedge clk) begin
        if (job.start) begin
            row_r   <= job.row_data;
            entry_r <= job.entry;
        end
        if (write) begin
            linebuf_wridx  <= lb_idx;
            linebuf_wrdata <= pix;
        end
    end

endmodule

/* logic/render_pkg.sv */
package render_pkg;

    // Widths and limits
    localparam int LINE_PIXELS = 640;
    localparam int REG_ADDR_W  = 4;
    localparam int REG_DATA_W  = 8;
    localparam int BUS_ADDR_W  = 18;
    localparam int BUS_DATA_W  = 32;
    localparam int LB_IDX_W    = 10;

    ////////////////////////////////////////
    // Register map
    ////////////////////////////////////////
    localparam logic [REG_ADDR_W-1:0] REG_CTRL0       = 4'h0;
    localparam logic [REG_ADDR_W-1:0] REG_CTRL1       = 4'h1;
    localparam logic [REG_ADDR_W-1:0] REG_MAP_BASE_L  = 4'h2;
    localparam logic [REG_ADDR_W-1:0] REG_MAP_BASE_H  = 4'h3;
    localparam logic [REG_ADDR_W-1:0] REG_TILE_BASE_L = 4'h4;
    localparam logic [REG_ADDR_W-1:0] REG_TILE_BASE_H = 4'h5;
    localparam logic [REG_ADDR_W-1:0] REG_HSCROLL_L   = 4'h6;
    localparam logic [REG_ADDR_W-1:0] REG_HSCROLL_H   = 4'h7;
    localparam logic [REG_ADDR_W-1:0] REG_VSCROLL_L   = 4'h8;
    localparam logic [REG_ADDR_W-1:0] REG_VSCROLL_H   = 4'h9;

    // Mode codes, CTRL0 bit 0
    localparam logic MODE_1BPP = 1'b0;
    localparam logic MODE_4BPP = 1'b1;

    localparam logic [15:0] TILE_BASE_RESET = 16'h8000;

    // Fetch FSM states
    localparam logic [2:0] ST_IDLE       = 3'd0;
    localparam logic [2:0] ST_FETCH_MAP  = 3'd1;
    localparam logic [2:0] ST_WAIT_MAP   = 3'd2;
    localparam logic [2:0] ST_FETCH_TILE = 3'd3;
    localparam logic [2:0] ST_WAIT_TILE  = 3'd4;
    localparam logic [2:0] ST_ISSUE      = 3'd5;

    typedef enum logic {
        RENDER_1BPP = MODE_1BPP,
        RENDER_4BPP = MODE_4BPP
    } render_mode_t;

    // One map halfword, read differently per mode
    typedef union packed {
        struct packed {
            logic [3:0] bg;
            logic [3:0] fg;
            logic [7:0] tile;
        } attr1;
        struct packed {
            logic [3:0] palette;
            logic [1:0] rsvd;
            logic [9:0] tile;
        } attr4;
    } map_entry_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Compile and run the layer renderer testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_layer_renderer -f sources.f -o tb_layer_renderer
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_layer_renderer > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

/* sim/layer_renderer_asserts.sv */
module layer_renderer_asserts (
    input logic       clk,
    input logic       rst,
    input logic       bus_strobe,
    input logic       bus_ack,
    input logic [2:0] state,
    input logic       job_start,
    input logic       job_busy
);

    timeunit 1ns;
    timeprecision 100ps;

    // Read by the testbench at the end of the run
    int fail_count = 0;

    ////////////////////////////////////////
    // Bus handshake
    ////////////////////////////////////////

    // A request holds until the memory acknowledges it
    strobe_held: assert property (@(posedge clk) disable iff (rst)
        bus_strobe |=> (bus_strobe || bus_ack))
    else begin
        $error("bus_strobe dropped before bus_ack");
        fail_count++;
    end

    idle_quiet: assert property (@(posedge clk) disable iff (rst)
        (state == render_pkg::ST_IDLE) |-> !bus_strobe)
    else begin
        $error("bus_strobe high while the fetch FSM is idle");
        fail_count++;
    end

    ////////////////////////////////////////
    // Pixel job handoff
    ////////////////////////////////////////
    start_when_free: assert property (@(posedge clk) disable iff (rst)
        job_start |-> !job_busy)
    else begin
        $error("job start issued while the pixel writer is busy");
        fail_count++;
    end

endmodule

bind fetch_ctrl layer_renderer_asserts asserts0 (
    .clk(clk),
    .rst(rst),
    .bus_strobe(bus_strobe),
    .bus_ack(bus_ack),
    .state(state),
    .job_start(job.start),
    .job_busy(job.busy)
);

/* sim/tb_layer_renderer.sv */
module tb_layer_renderer;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NPIX         = render_pkg::LINE_PIXELS;
    localparam int LINE_CYCLES  = 1200;
    localparam int NUM_LINES    = 10;
    localparam int TOTAL_CYCLES = NUM_LINES * LINE_CYCLES + 300;

    logic        clk;
    logic        rst;
    logic        start_of_screen;
    logic        start_of_line;
    logic [3:0]  regs_addr;
    logic [7:0]  regs_wrdata;
    logic        regs_write;
    logic [7:0]  regs_rddata;
    logic [17:0] bus_addr;
    logic [31:0] bus_rddata;
    logic        bus_strobe;
    logic        bus_ack;
    logic [9:0]  linebuf_wridx;
    logic [7:0]  linebuf_wrdata;
    logic        linebuf_wren;

    logic [31:0] mem [0:65535];
    logic [7:0]  line_buf [0:NPIX-1];
    logic [7:0]  saved_line [0:NPIX-1];
    int          wr_count;
    int          errors;
    int          checks;
    int          line_no;
    int          seed = 37;
    bit          stall_en = 1'b1;

    // Expected layer settings track the register writes
    logic        sh_mode;
    logic [1:0]  sh_mw;
    logic [1:0]  sh_mh;
    logic [15:0] sh_map_base;
    logic [15:0] sh_tile_base;
    logic [11:0] sh_hscroll;
    logic [11:0] sh_vscroll;

    layer_renderer dut0 (
        .clk(clk), .rst(rst), .start_of_screen(start_of_screen),
        .start_of_line(start_of_line), .regs_addr(regs_addr), .regs_wrdata(regs_wrdata),
        .regs_write(regs_write), .regs_rddata(regs_rddata), .bus_addr(bus_addr),
        .bus_rddata(bus_rddata), .bus_strobe(bus_strobe), .bus_ack(bus_ack),
        .linebuf_wridx(linebuf_wridx), .linebuf_wrdata(linebuf_wrdata),
        .linebuf_wren(linebuf_wren)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Video memory and line buffer models
    ////////////////////////////////////////
    initial begin : memory_model
        int delay;
        bus_ack    = 1'b0;
        bus_rddata = '0;
        forever begin
            @(posedge clk);
            #1;
            if (bus_ack) begin
                bus_ack = 1'b0;
            end else if (!rst && bus_strobe) begin
                // Word bus, every request is word aligned
                checks++;
                if (bus_addr[1:0] !== 2'b00) begin
                    errors++;
                    $display("mismatch bus_addr[1:0]: got %h, expected %h",
                             bus_addr[1:0], 2'b00);
                end
                delay = stall_en ? int'($unsigned($random(seed)) % 4) : 0;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                bus_rddata = mem[bus_addr[17:2]];
                bus_ack    = 1'b1;
            end
        end
    end

    // Writes land in order with one index per pixel
    always @(negedge clk) begin
        if (!rst && linebuf_wren) begin
            checks++;
            if (wr_count >= NPIX) begin
                errors++;
                $display("Write past the end of the line at index %0d", linebuf_wridx);
            end else if (linebuf_wridx !== wr_count[9:0]) begin
                errors++;
                $display("mismatch linebuf_wridx: got %h, expected %h",
                         linebuf_wridx, wr_count[9:0]);
            end
            if (linebuf_wridx < NPIX) begin
                line_buf[linebuf_wridx] = linebuf_wrdata;
            end
            wr_count++;
        end
    end

    initial begin : watchdog
        #(20 * TOTAL_CYCLES * 10);
        $display("Watchdog expired after %0d cycles, run stopped", 20 * TOTAL_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////
    // Reference pixel
    ////////////////////////////////////////
    function automatic logic [7:0] ref_pixel(input int line, input int x);
        logic [11:0] scrolled;
        int          cols;
        int          mrow;
        int          mcol;
        int          idx;
        int          p;
        logic [31:0] word;
        logic [15:0] entry;
        logic [7:0]  row_byte;
        logic [3:0]  nib;
        scrolled = 12'(line) + sh_vscroll;
        cols     = 32 << sh_mw;
        mrow     = (int'(scrolled) / 8) % (32 << sh_mh);
        mcol     = (x / 8 + int'(sh_hscroll) / 8) % cols;
        idx      = mrow * cols + mcol;
        word     = mem[16'(int'(sh_map_base) + idx / 2)];
        entry    = (idx % 2 == 1) ? word[31:16] : word[15:0];
        p        = x % 8;
        if (sh_mode) begin
            // 4 bpp reads byte 0 first and the high nibble first
            word = mem[16'(int'(sh_tile_base) + int'(entry[9:0]) * 8 + int'(scrolled[2:0]))];
            nib  = 4'(word >> (8 * (p / 2) + ((p % 2 == 0) ? 4 : 0)));
            return (nib != 4'h0) ? {entry[15:12], nib} : 8'h00;
        end
        word     = mem[16'(int'(sh_tile_base) + int'(entry[7:0]) * 2 + int'(scrolled[2]))];
        row_byte = 8'(word >> (8 * int'(scrolled[1:0])));
        return row_byte[7 - p] ? {4'h0, entry[11:8]} : {4'h0, entry[15:12]};
    endfunction

    function automatic logic [7:0] field_mask(input logic [3:0] addr);
        case (addr)
            render_pkg::REG_CTRL0:     return 8'h01;
            render_pkg::REG_CTRL1:     return 8'h0F;
            render_pkg::REG_HSCROLL_H: return 8'h0F;
            render_pkg::REG_VSCROLL_H: return 8'h0F;
            default:                   return 8'hFF;
        endcase
    endfunction

    ////////////////////////////////////////
    // Drive helpers
    ////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
        regs_addr   = addr;
        regs_wrdata = data;
        regs_write  = 1'b1;
        next_cycle();
        regs_write  = 1'b0;
    endtask

    task automatic check_reg(input logic [3:0] addr, input logic [7:0] expected);
        regs_addr = addr;
        @(negedge clk);
        checks++;
        if (regs_rddata !== expected) begin
            errors++;
            $display("mismatch regs_rddata at %h: got %h, expected %h",
                     addr, regs_rddata, expected);
        end
        next_cycle();
    endtask

    task automatic set_layer(input logic mode, input logic [1:0] mw, input logic [1:0] mh,
                             input logic [15:0] map_base, input logic [15:0] tile_base,
                             input logic [11:0] hscroll, input logic [11:0] vscroll);
        write_reg(render_pkg::REG_CTRL0, {7'b0, mode});
        write_reg(render_pkg::REG_CTRL1, {4'b0, mh, mw});
        write_reg(render_pkg::REG_MAP_BASE_L, map_base[7:0]);
        write_reg(render_pkg::REG_MAP_BASE_H, map_base[15:8]);
        write_reg(render_pkg::REG_TILE_BASE_L, tile_base[7:0]);
        write_reg(render_pkg::REG_TILE_BASE_H, tile_base[15:8]);
        write_reg(render_pkg::REG_HSCROLL_L, hscroll[7:0]);
        write_reg(render_pkg::REG_HSCROLL_H, {4'b0, hscroll[11:8]});
        write_reg(render_pkg::REG_VSCROLL_L, vscroll[7:0]);
        write_reg(render_pkg::REG_VSCROLL_H, {4'b0, vscroll[11:8]});
        sh_mode      = mode;
        sh_mw        = mw;
        sh_mh        = mh;
        sh_map_base  = map_base;
        sh_tile_base = tile_base;
        sh_hscroll   = hscroll;
        sh_vscroll   = vscroll;
    endtask

    task automatic new_screen();
        start_of_screen = 1'b1;
        next_cycle();
        start_of_screen = 1'b0;
        line_no         = 0;
    endtask

    // Render one line and compare it with the reference
    task automatic run_line();
        int         x;
        int         cycles;
        int         shown;
        logic [7:0] expected;
        for (x = 0; x < NPIX; x++) begin
            line_buf[x] = 'x;
        end
        wr_count      = 0;
        start_of_line = 1'b1;
        next_cycle();
        start_of_line = 1'b0;
        cycles        = 0;
        while (wr_count < NPIX && cycles < 4 * LINE_CYCLES) begin
            next_cycle();
            cycles++;
        end
        if (wr_count < NPIX) begin
            errors++;
            $display("Line %0d timed out with %0d of %0d pixels written",
                     line_no, wr_count, NPIX);
        end
        // Nothing more may be written in the quiet window
        repeat (20) next_cycle();
        checks += 2;
        if (wr_count != NPIX) begin
            errors++;
            $display("mismatch linebuf_wren count: got %h, expected %h", wr_count, NPIX);
        end
        if (bus_strobe !== 1'b0) begin
            errors++;
            $display("mismatch bus_strobe after line: got %h, expected 0", bus_strobe);
        end
        shown = 0;
        for (x = 0; x < NPIX; x++) begin
            expected = ref_pixel(line_no, x);
            checks++;
            if (line_buf[x] !== expected) begin
                errors++;
                if (shown < 8) begin
                    $display("mismatch linebuf_wrdata[%0d] line %0d: got %h, expected %h",
                             x, line_no, line_buf[x], expected);
                end
                shown++;
            end
        end
        line_no++;
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic register_access();
        logic [7:0] written [0:9];
        int         a;
        // Only the tile base comes out of reset nonzero
        for (a = 0; a < 10; a++) begin
            check_reg(4'(a), (4'(a) == render_pkg::REG_TILE_BASE_H) ? 8'h80 : 8'h00);
        end
        for (a = 0; a < 10; a++) begin
            written[a] = 8'(32'hA5 ^ (a * 37));
            write_reg(4'(a), written[a]);
        end
        for (a = 0; a < 10; a++) begin
            check_reg(4'(a), written[a] & field_mask(4'(a)));
        end
        write_reg(4'hC, 8'hFF);
        check_reg(4'hC, 8'h00);
        check_reg(4'hF, 8'h00);
    endtask

    task automatic mode0_line();
        set_layer(1'b0, 2'd1, 2'd1, 16'h1000, 16'h8000, 12'h005, 12'h013);
        new_screen();
        run_line();
    endtask

    task automatic mode1_line();
        set_layer(1'b1, 2'd2, 2'd0, 16'h2345, 16'h4000, 12'h01A, 12'h006);
        new_screen();
        run_line();
    endtask

    task automatic scroll_and_wrap();
        // Rows and columns of the small map wrap within these lines
        set_layer(1'b0, 2'd0, 2'd0, 16'hFF00, 16'h7FF0, 12'h0FB, 12'hFFE);
        new_screen();
        repeat (3) run_line();
        set_layer(1'b1, 2'd3, 2'd3, 16'h0800, 16'hF000, 12'hFFF, 12'h7FE);
        new_screen();
        repeat (3) run_line();
    endtask

    task automatic bus_stall_line();
        int x;
        set_layer(1'b1, 2'd3, 2'd3, 16'hFFF0, 16'hC000, 12'h0F0, 12'h100);
        stall_en = 1'b0;
        new_screen();
        run_line();
        for (x = 0; x < NPIX; x++) begin
            saved_line[x] = line_buf[x];
        end
        stall_en = 1'b1;
        new_screen();
        run_line();
        for (x = 0; x < NPIX; x++) begin
            checks++;
            if (line_buf[x] !== saved_line[x]) begin
                errors++;
                $display("mismatch linebuf_wrdata[%0d] with stalls: got %h, expected %h",
                         x, line_buf[x], saved_line[x]);
            end
        end
    endtask

    initial begin
        rst             = 1'b1;
        start_of_screen = 1'b0;
        start_of_line   = 1'b0;
        regs_addr       = '0;
        regs_wrdata     = '0;
        regs_write      = 1'b0;
        wr_count        = 0;
        errors          = 0;
        checks          = 0;
        line_no         = 0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = $random(seed);
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        next_cycle();

        register_access();
        mode0_line();
        mode1_line();
        scroll_and_wrap();
        bus_stall_line();

        errors += dut0.ctrl0.asserts0.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sources.f */
logic/render_pkg.sv
logic/layer_cfg_if.sv
logic/pixel_job_if.sv
logic/layer_regs.sv
logic/fetch_addr.sv
logic/fetch_ctrl.sv
logic/pixel_writer.sv
logic/layer_renderer.sv
sim/layer_renderer_asserts.sv
sim/tb_layer_renderer.sv
